/* allocator/switch_alloc_global.sv */
// global switch allocation of one output port
// round robin over the inputs that request this output
// pointer advances only on a successful VC assignment

`timescale 1ns/100ps

module switch_alloc_global (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  router_pkg::port_oh_t  req_i,
  input  logic                  advance_i,
  output router_pkg::port_oh_t  grant_o
);

  router_pkg::port_id_t ptr;
  router_pkg::port_id_t win_id;
  logic                 win_v;

  // first requesting input at or after the pointer
  always_comb begin
    int idx;
    win_v  = 1'b0;
    win_id = '0;
    for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
      idx = (int'(ptr) + i) % router_pkg::NUM_PORTS;
      if (!win_v && req_i[idx]) begin
        win_v  = 1'b1;
        win_id = router_pkg::port_id_t'(idx);
      end
    end
  end

  assign grant_o = win_v ? router_pkg::port_oh_t'(1) << win_id : '0;

  // a grant without a free output VC keeps its priority
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr <= '0;
    end else if (advance_i) begin
      ptr <= router_pkg::port_id_t'((int'(win_id) + 1) % router_pkg::NUM_PORTS);
    end
  end

endmodule

/* allocator/switch_alloc_local.sv */
// local switch allocation of one input port
// round robin over the VCs that hold a head flit
// one-hot request toward the chosen head's destination

`timescale 1ns/100ps

module switch_alloc_local (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  vc_head_if.alloc              head,
  input  logic                  pop_i,
  output router_pkg::port_oh_t  req_o,
  output router_pkg::vc_id_t    req_vc_o
);

  router_pkg::vc_id_t ptr;
  router_pkg::vc_id_t sel_vc;
  logic               sel_v;

  // first valid head at or after the pointer
  always_comb begin
    int idx;
    sel_v  = 1'b0;
    sel_vc = '0;
    for (int i = 0; i < router_pkg::NUM_VC; i++) begin
      idx = (int'(ptr) + i) % router_pkg::NUM_VC;
      if (!sel_v && head.head_v[idx]) begin
        sel_v  = 1'b1;
        sel_vc = router_pkg::vc_id_t'(idx);
      end
    end
  end

  assign req_o    = sel_v ? router_pkg::port_oh_t'(1) <<
                            router_pkg::flit_dest(head.head_flit[sel_vc]) : '0;
  assign req_vc_o = sel_vc;

  // pop_i only comes back for a granted and assigned request
  assign head.pop    = pop_i;
  assign head.pop_vc = sel_vc;

  // move past the winner only once it has left
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr <= '0;
    end else if (pop_i) begin
      ptr <= router_pkg::vc_id_t'((int'(sel_vc) + 1) % router_pkg::NUM_VC);
    end
  end

endmodule

/* common/router_pkg.sv */
// router-wide sizes for ports, virtual channels and buffer depth
// vector typedefs for port, VC, credit and flit fields
// flit field positions and small field access functions

package router_pkg;

  // N, E, S, W, local
  localparam int NUM_PORTS = 5;
  localparam int NUM_VC    = 2;
  // flits per VC buffer, also the initial credits of an output VC
  localparam int VC_DEPTH  = 2;

  localparam int PORT_ID_W = $clog2(NUM_PORTS);
  localparam int VC_ID_W   = $clog2(NUM_VC);
  localparam int CREDIT_W  = $clog2(VC_DEPTH + 1);
  localparam int PTR_W     = $clog2(VC_DEPTH);

  typedef logic [PORT_ID_W-1:0] port_id_t;
  typedef logic [NUM_PORTS-1:0] port_oh_t;
  typedef logic [VC_ID_W-1:0]   vc_id_t;
  typedef logic [NUM_VC-1:0]    vc_oh_t;
  typedef logic [CREDIT_W-1:0]  credit_cnt_t;
  typedef logic [PTR_W-1:0]     buf_ptr_t;
  typedef logic [15:0]          payload_t;

  // flit layout from the top: destination port, VC id, payload
  localparam int FLIT_VC_LSB   = $bits(payload_t);
  localparam int FLIT_DEST_LSB = FLIT_VC_LSB + VC_ID_W;
  localparam int FLIT_W        = FLIT_DEST_LSB + PORT_ID_W;

  typedef logic [FLIT_W-1:0] flit_t;

  function automatic port_id_t flit_dest(flit_t f);
    return f[FLIT_DEST_LSB +: PORT_ID_W];
  endfunction

  function automatic vc_id_t flit_vc(flit_t f);
    return f[FLIT_VC_LSB +: VC_ID_W];
  endfunction

  // same flit with its VC field replaced
  function automatic flit_t flit_set_vc(flit_t f, vc_id_t vc);
    flit_t r;
    r = f;
    r[FLIT_VC_LSB +: VC_ID_W] = vc;
    return r;
  endfunction

endpackage

/* common/vc_head_if.sv */
// head flits of one input port toward its allocator slice
// pop request back from the allocator to the VC buffers

`timescale 1ns/100ps

interface vc_head_if;

  // one valid bit and one oldest flit per VC
  router_pkg::vc_oh_t                            head_v;
  router_pkg::flit_t [router_pkg::NUM_VC-1:0]    head_flit;

  // pop may only name a VC whose head_v is set
  logic                                          pop;
  router_pkg::vc_id_t                            pop_vc;

  modport buffer (
    output head_v,
    output head_flit,
    input  pop,
    input  pop_vc
  );

  modport alloc (
    input  head_v,
    input  head_flit,
    output pop,
    output pop_vc
  );

endinterface

/* input_port/vc_input_port.sv */
// input port of the router
// one circular buffer per VC, oldest flit of each VC shown as head
// registered credit pulse for every popped flit

`timescale 1ns/100ps

module vc_input_port (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               data_v_i,
  input  router_pkg::flit_t  data_i,
  output logic               credit_v_o,
  output router_pkg::vc_id_t credit_id_o,
  vc_head_if.buffer          head
);

  router_pkg::flit_t                           mem [router_pkg::NUM_VC][router_pkg::VC_DEPTH];
  router_pkg::buf_ptr_t [router_pkg::NUM_VC-1:0]    wr_ptr;
  router_pkg::buf_ptr_t [router_pkg::NUM_VC-1:0]    rd_ptr;
  router_pkg::credit_cnt_t [router_pkg::NUM_VC-1:0] cnt;

  router_pkg::vc_id_t in_vc;
  router_pkg::vc_oh_t push;
  router_pkg::vc_oh_t pop;

  function automatic router_pkg::buf_ptr_t ptr_next(router_pkg::buf_ptr_t p);
    if (p == router_pkg::buf_ptr_t'(router_pkg::VC_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // incoming header selects the buffer
  assign in_vc = router_pkg::flit_vc(data_i);
  assign push  = data_v_i ? router_pkg::vc_oh_t'(1) << in_vc : '0;
  assign pop   = head.pop ? router_pkg::vc_oh_t'(1) << head.pop_vc : '0;

  always_ff @(posedge clk_i) begin
    if (data_v_i) begin
      mem[in_vc][wr_ptr[in_vc]] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      for (int v = 0; v < router_pkg::NUM_VC; v++) begin
        if (push[v]) begin
          wr_ptr[v] <= ptr_next(wr_ptr[v]);
        end
        if (pop[v]) begin
          rd_ptr[v] <= ptr_next(rd_ptr[v]);
        end
        // upstream only sends with credit, so no overflow here
        cnt[v] <= cnt[v] + router_pkg::credit_cnt_t'(push[v])
                         - router_pkg::credit_cnt_t'(pop[v]);
      end
    end
  end

  // head presentation
  always_comb begin
    for (int v = 0; v < router_pkg::NUM_VC; v++) begin
      head.head_v[v]    = (cnt[v] != '0);
      head.head_flit[v] = mem[v][rd_ptr[v]];
    end
  end

  // freed slot goes back upstream one cycle after the pop
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_v_o  <= 1'b0;
      credit_id_o <= '0;
    end else begin
      credit_v_o  <= head.pop;
      credit_id_o <= head.pop_vc;
    end
  end

endmodule

/* output_port/output_vc_credits.sv */
// credit counters of one output port
// lowest VC with credit left is selected
// assignment to a granted flit consumes one credit

`timescale 1ns/100ps

module output_vc_credits (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                credit_v_i,
  input  router_pkg::vc_id_t  credit_id_i,
  input  logic                grant_v_i,
  output logic                assign_v_o,
  output router_pkg::vc_id_t  assign_vc_o
);

  router_pkg::credit_cnt_t [router_pkg::NUM_VC-1:0] cnt;

  router_pkg::vc_id_t free_vc;
  logic               free_v;

  // VC selection, lowest index wins
  always_comb begin
    free_v  = 1'b0;
    free_vc = '0;
    for (int v = 0; v < router_pkg::NUM_VC; v++) begin
      if (!free_v && cnt[v] != '0) begin
        free_v  = 1'b1;
        free_vc = router_pkg::vc_id_t'(v);
      end
    end
  end

  assign assign_v_o  = grant_v_i && free_v;
  assign assign_vc_o = free_vc;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int v = 0; v < router_pkg::NUM_VC; v++) begin
        cnt[v] <= router_pkg::credit_cnt_t'(router_pkg::VC_DEPTH);
      end
    end else begin
      for (int v = 0; v < router_pkg::NUM_VC; v++) begin
        // consumed and returned together leaves the count as is
        if (credit_v_i && credit_id_i == router_pkg::vc_id_t'(v) &&
            !(assign_v_o && assign_vc_o == router_pkg::vc_id_t'(v))) begin
          cnt[v] <= cnt[v] + 1'b1;
        end else if (assign_v_o && assign_vc_o == router_pkg::vc_id_t'(v) &&
                     !(credit_v_i && credit_id_i == router_pkg::vc_id_t'(v))) begin
          cnt[v] <= cnt[v] - 1'b1;
        end
      end
    end
  end

endmodule

/* output_port/switch_traversal.sv */
// switch traversal of one output port
// flit of the granted input, VC field rewritten to the assigned VC
// registered toward the output link

`timescale 1ns/100ps

module switch_traversal (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic                                         assign_v_i,
  input  router_pkg::vc_id_t                           assign_vc_i,
  input  router_pkg::port_oh_t                         grant_i,
  input  router_pkg::flit_t [router_pkg::NUM_PORTS-1:0] in_flit_i,
  output logic                                         data_v_o,
  output router_pkg::flit_t                            data_o
);

  router_pkg::flit_t mux_flit;
  router_pkg::flit_t out_flit;

  // grant is one-hot, so an OR of masked flits is the mux
  always_comb begin
    mux_flit = '0;
    for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
      mux_flit = mux_flit | (in_flit_i[p] & {router_pkg::FLIT_W{grant_i[p]}});
    end
  end

  assign out_flit = router_pkg::flit_set_vc(mux_flit, assign_vc_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_v_o <= 1'b0;
    end else begin
      data_v_o <= assign_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (assign_v_i) begin
      data_o <= out_flit;
    end
  end

endmodule

/* rtl/vc_router.sv */
// five-port virtual-channel router top level
// input buffers, two-stage switch allocation, credits and traversal
// transposition of per-input requests into per-output vectors

`timescale 1ns/100ps

module vc_router (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  input  logic               [router_pkg::NUM_PORTS-1:0]  data_v_i,
  input  router_pkg::flit_t  [router_pkg::NUM_PORTS-1:0]  data_i,
  output logic               [router_pkg::NUM_PORTS-1:0]  credit_v_o,
  output router_pkg::vc_id_t [router_pkg::NUM_PORTS-1:0]  credit_id_o,
  input  logic               [router_pkg::NUM_PORTS-1:0]  credit_v_i,
  input  router_pkg::vc_id_t [router_pkg::NUM_PORTS-1:0]  credit_id_i,
  output logic               [router_pkg::NUM_PORTS-1:0]  data_v_o,
  output router_pkg::flit_t  [router_pkg::NUM_PORTS-1:0]  data_o
);

  // per input
  router_pkg::port_oh_t [router_pkg::NUM_PORTS-1:0] local_req;
  router_pkg::vc_id_t   [router_pkg::NUM_PORTS-1:0] local_vc;
  router_pkg::flit_t    [router_pkg::NUM_PORTS-1:0] sel_flit;
  logic                 [router_pkg::NUM_PORTS-1:0] pop;
  // per output
  router_pkg::port_oh_t [router_pkg::NUM_PORTS-1:0] out_req;
  router_pkg::port_oh_t [router_pkg::NUM_PORTS-1:0] grant;
  logic                 [router_pkg::NUM_PORTS-1:0] assign_v;
  router_pkg::vc_id_t   [router_pkg::NUM_PORTS-1:0] assign_vc;

  vc_head_if head_if [router_pkg::NUM_PORTS] ();

  // ==========================================================================
  // input side: buffers and local allocation
  // ==========================================================================

  for (genvar p = 0; p < router_pkg::NUM_PORTS; p++) begin : gen_in
    vc_input_port u_in_port (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p]),
      .head        (head_if[p])
    );

    switch_alloc_local u_sa_local (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .head     (head_if[p]),
      .pop_i    (pop[p]),
      .req_o    (local_req[p]),
      .req_vc_o (local_vc[p])
    );

    assign sel_flit[p] = head_if[p].head_flit[local_vc[p]];
  end

  // ==========================================================================
  // input to output mapping
  // ==========================================================================

  always_comb begin
    for (int o = 0; o < router_pkg::NUM_PORTS; o++) begin
      for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
        out_req[o][i] = local_req[i][o];
      end
    end
  end

  // an input leaves when its output granted it and found a free VC
  always_comb begin
    pop = '0;
    for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
      for (int o = 0; o < router_pkg::NUM_PORTS; o++) begin
        pop[i] = pop[i] | (grant[o][i] & assign_v[o]);
      end
    end
  end

  // ==========================================================================
  // output side: global allocation, credits, traversal
  // ==========================================================================

  for (genvar o = 0; o < router_pkg::NUM_PORTS; o++) begin : gen_out
    switch_alloc_global u_sa_global (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .req_i     (out_req[o]),
      .advance_i (assign_v[o]),
      .grant_o   (grant[o])
    );

    output_vc_credits u_credits (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .credit_v_i  (credit_v_i[o]),
      .credit_id_i (credit_id_i[o]),
      .grant_v_i   (|grant[o]),
      .assign_v_o  (assign_v[o]),
      .assign_vc_o (assign_vc[o])
    );

    switch_traversal u_st (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .assign_v_i  (assign_v[o]),
      .assign_vc_i (assign_vc[o]),
      .grant_i     (grant[o]),
      .in_flit_i   (sel_flit),
      .data_v_o    (data_v_o[o]),
      .data_o      (data_o[o])
    );
  end

endmodule

/* sources.f */
common/router_pkg.sv
common/vc_head_if.sv
input_port/vc_input_port.sv
allocator/switch_alloc_local.sv
allocator/switch_alloc_global.sv
output_port/output_vc_credits.sv
output_port/switch_traversal.sv
rtl/vc_router.sv
test/vc_router_asserts.sv
test/tb_vc_router.sv

/* test/tb_vc_router.sv */
// testbench for the five-port VC router
// random credit-driven upstream traffic, downstream credit return with delays
// reference queues per input VC and destination, idle latency and back-pressure

`timescale 1ns/100ps

module tb_vc_router;

  localparam int NP = router_pkg::NUM_PORTS;
  localparam int NV = router_pkg::NUM_VC;
  localparam int DEPTH = router_pkg::VC_DEPTH;

  logic                                    clk_i;
  logic                                    arst_n_i;
  logic               [NP-1:0]             data_v_i;
  router_pkg::flit_t  [NP-1:0]             data_i;
  logic               [NP-1:0]             credit_v_o;
  router_pkg::vc_id_t [NP-1:0]             credit_id_o;
  logic               [NP-1:0]             credit_v_i;
  router_pkg::vc_id_t [NP-1:0]             credit_id_i;
  logic               [NP-1:0]             data_v_o;
  router_pkg::flit_t  [NP-1:0]             data_o;

  // expected payloads per source input, source VC and destination
  router_pkg::payload_t exp_q [NP][NV][NP][$];
  // downstream credits waiting to be returned, per output
  router_pkg::vc_id_t   ret_q [NP][$];

  int                 up_cnt [NP][NV];
  int                 seq    [NP][NV];
  int                 tb_cnt [NP][NV];
  logic               pend_v  [NP];
  router_pkg::vc_id_t pend_id [NP];
  int                 pending;
  bit                 withhold;
  string              test_name;

  vc_router uut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i),
    .data_v_o    (data_v_o),
    .data_o      (data_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_flit(input router_pkg::flit_t exp, input router_pkg::flit_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("error %s: expected flit %h, actual flit %h",
                                  test_name, exp, act));
    end
  endtask

  task automatic check_credit(input router_pkg::vc_id_t exp, input router_pkg::vc_id_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("error %s: expected credit VC %0d, actual credit VC %0d",
                                  test_name, exp, act));
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
      stop_with_failure($sformatf("error %s: expected latency %0d, actual latency %0d",
                                  test_name, exp, act));
    end
  endtask

  // lowest output VC that still holds credit by our own count
  function automatic int lowest_free_vc(input int o);
    for (int v = 0; v < NV; v++) begin
      if (tb_cnt[o][v] > 0) begin
        return v;
      end
    end
    return -1;
  endfunction

  function automatic int open_returns();
    int n;
    n = 0;
    for (int o = 0; o < NP; o++) begin
      n += ret_q[o].size();
    end
    return n;
  endfunction

  // payload tag is input, VC and sequence number
  task automatic inject(input int i, input int v, input int d);
    router_pkg::payload_t pl;
    pl = {router_pkg::port_id_t'(i), router_pkg::vc_id_t'(v), 12'(seq[i][v])};
    data_v_i[i] = 1'b1;
    data_i[i]   = {router_pkg::port_id_t'(d), router_pkg::vc_id_t'(v), pl};
    exp_q[i][v][d].push_back(pl);
    up_cnt[i][v]--;
    seq[i][v]++;
    pending++;
  endtask

  task automatic drive_upstream(input bit traffic);
    int v;
    int d;
    for (int i = 0; i < NP; i++) begin
      data_v_i[i] = 1'b0;
      if (traffic && ($urandom % 3 != 0)) begin
        v = $urandom % NV;
        if (up_cnt[i][v] == 0) begin
          v = (v + 1) % NV;
        end
        if (up_cnt[i][v] != 0) begin
          // never back to the input's own port
          d = $urandom % (NP - 1);
          if (d >= i) begin
            d++;
          end
          inject(i, v, d);
        end
      end
    end
  endtask

  task automatic drive_downstream();
    for (int o = 0; o < NP; o++) begin
      credit_v_i[o] = 1'b0;
      if (!withhold && ret_q[o].size() != 0 && ($urandom % 3 != 0)) begin
        credit_v_i[o]  = 1'b1;
        credit_id_i[o] = ret_q[o].pop_front();
      end
    end
  endtask

  task automatic tick(input bit traffic);
    @(posedge clk_i);
    #2;
    drive_upstream(traffic);
    drive_downstream();
  endtask

  // ==========================================================================
  // output and credit monitor
  // ==========================================================================

  task automatic monitor_outputs();
    int                   hits   [NP];
    router_pkg::vc_id_t   hit_vc [NP];
    router_pkg::flit_t    f;
    router_pkg::flit_t    exp_f;
    router_pkg::payload_t pl;
    int                   src;
    int                   sv;
    int                   ov;
    for (int i = 0; i < NP; i++) begin
      hits[i]   = 0;
      hit_vc[i] = '0;
    end
    for (int o = 0; o < NP; o++) begin
      if (data_v_o[o]) begin
        f   = data_o[o];
        pl  = f[15:0];
        src = int'(pl[15:13]);
        sv  = int'(pl[12]);
        if (src >= NP || exp_q[src][sv][o].size() == 0) begin
          stop_with_failure($sformatf("output %0d sent a flit nobody sent to it", o));
        end
        ov = lowest_free_vc(o);
        if (ov < 0) begin
          stop_with_failure($sformatf("output %0d sent a flit with no credit left", o));
        end
        exp_f = {router_pkg::port_id_t'(o), router_pkg::vc_id_t'(ov),
                 exp_q[src][sv][o].pop_front()};
        check_flit(exp_f, f);
        tb_cnt[o][ov]--;
        ret_q[o].push_back(router_pkg::vc_id_t'(ov));
        pending--;
        hits[src]++;
        hit_vc[src] = router_pkg::vc_id_t'(sv);
      end
    end
    // a pop shows up as a credit in the same cycle as the flit
    for (int i = 0; i < NP; i++) begin
      if (credit_v_o[i]) begin
        if (hits[i] != 1) begin
          stop_with_failure($sformatf("input %0d returned a credit but no flit left it", i));
        end
        check_credit(hit_vc[i], credit_id_o[i]);
        up_cnt[i][credit_id_o[i]]++;
        if (up_cnt[i][credit_id_o[i]] > DEPTH) begin
          stop_with_failure($sformatf("input %0d returned more credits than it took", i));
        end
      end else if (hits[i] != 0) begin
        stop_with_failure($sformatf("a flit left input %0d without a credit coming back", i));
      end
    end
    // downstream credits reach the router counters one cycle late
    for (int o = 0; o < NP; o++) begin
      if (pend_v[o]) begin
        tb_cnt[o][pend_id[o]]++;
      end
      pend_v[o]  = credit_v_i[o];
      pend_id[o] = credit_id_i[o];
    end
  endtask

  always @(negedge clk_i) begin
    if (arst_n_i) begin
      monitor_outputs();
    end
  end

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (pending != 0 || open_returns() != 0) begin
      tick(1'b0);
      n++;
      if (n > limit) begin
        stop_with_failure("flits or credits still outstanding after the drain timeout");
      end
    end
    repeat (3) tick(1'b0);
  endtask

  task automatic run_latency(input int in_p, input int dest);
    int lat;
    @(posedge clk_i);
    #2;
    drive_downstream();
    data_v_i = '0;
    inject(in_p, 0, dest);
    lat = 0;
    do begin
      tick(1'b0);
      lat++;
      @(negedge clk_i);
      if (lat > 20) begin
        stop_with_failure("a single flit never reached its output on an idle router");
      end
    end while (!data_v_o[dest]);
    check_latency(2, lat);
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin
    void'($urandom(91));
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    withhold    = 1'b0;
    pending     = 0;
    test_name   = "reset";
    for (int p = 0; p < NP; p++) begin
      pend_v[p]  = 1'b0;
      pend_id[p] = '0;
      for (int v = 0; v < NV; v++) begin
        up_cnt[p][v] = DEPTH;
        tb_cnt[p][v] = DEPTH;
        seq[p][v]    = 0;
      end
    end
    repeat (5) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    repeat (2) tick(1'b0);

    test_name = "idle latency";
    for (int i = 0; i < NP; i++) begin
      run_latency(i, (i + 1) % NP);
      wait_drained(50);
    end

    test_name = "random traffic";
    repeat (400) tick(1'b1);
    wait_drained(1000);

    test_name = "back pressure";
    withhold = 1'b1;
    repeat (150) tick(1'b1);
    if (pending == 0) begin
      stop_with_failure("no flits were held back while downstream withheld credits");
    end
    withhold = 1'b0;
    wait_drained(2000);

    test_name = "credit balance";
    for (int p = 0; p < NP; p++) begin
      for (int v = 0; v < NV; v++) begin
        if (up_cnt[p][v] != DEPTH || tb_cnt[p][v] != DEPTH) begin
          stop_with_failure($sformatf("port %0d VC %0d did not get all credits back", p, v));
        end
      end
    end

    $display("test passed");
    $finish;
  end

endmodule

/* test/vc_router_asserts.sv */
// concurrent assertions for the router top level
// quiet outputs during reset, one pop per input, no send without credit

`timescale 1ns/100ps

module vc_router_asserts (
  input  logic                                                           clk_i,
  input  logic                                                           arst_n_i,
  input  logic                 [router_pkg::NUM_PORTS-1:0]               out_valid_i,
  input  router_pkg::flit_t    [router_pkg::NUM_PORTS-1:0]               out_data_i,
  input  logic                 [router_pkg::NUM_PORTS-1:0]               credit_valid_i,
  input  router_pkg::port_oh_t [router_pkg::NUM_PORTS-1:0]               grant_i,
  input  logic                 [router_pkg::NUM_PORTS-1:0]               assign_v_i,
  input  router_pkg::credit_cnt_t [router_pkg::NUM_PORTS-1:0][router_pkg::NUM_VC-1:0] credit_cnt_i
);

  // [input][output] departures in this cycle
  logic [router_pkg::NUM_PORTS-1:0][router_pkg::NUM_PORTS-1:0] leave;

  // counters as they stood when the flit on the link took its VC
  router_pkg::credit_cnt_t [router_pkg::NUM_PORTS-1:0][router_pkg::NUM_VC-1:0] cnt_q;

  always_comb begin
    for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
      for (int o = 0; o < router_pkg::NUM_PORTS; o++) begin
        leave[i][o] = grant_i[o][i] & assign_v_i[o];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    cnt_q <= credit_cnt_i;
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> (out_valid_i == '0 && credit_valid_i == '0))
    else $error("router output or credit pulse active during reset");

  for (genvar i = 0; i < router_pkg::NUM_PORTS; i++) begin : gen_pop
    a_pop_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(leave[i]))
      else $error("input %0d popped toward more than one output", i);
  end

  // the VC named in the departing flit must have held a credit
  for (genvar o = 0; o < router_pkg::NUM_PORTS; o++) begin : gen_credit
    a_send_with_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_i[o] |-> cnt_q[o][router_pkg::flit_vc(out_data_i[o])] != '0)
      else $error("output %0d sent a flit on a VC with no credit", o);
  end

endmodule

bind vc_router vc_router_asserts u_asserts (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .out_valid_i    (data_v_o),
  .out_data_i     (data_o),
  .credit_valid_i (credit_v_o),
  .grant_i        (grant),
  .assign_v_i     (assign_v),
  .credit_cnt_i   ({gen_out[4].u_credits.cnt, gen_out[3].u_credits.cnt,
                    gen_out[2].u_credits.cnt, gen_out[1].u_credits.cnt,
                    gen_out[0].u_credits.cnt})
);
